/* logic/ooo_consts.svh */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// datapath width
`define DATA_W 16

// architectural and physical register files
`define NUM_ARN 8
`define ARN_W 3
`define NUM_PRN 16
`define PRN_W 4
`define ZERO_REG `ARN_W'd0

// window sizes
`define ROB_SZ 8
`define ROBN_W 3
`define RS_SZ 4
`define MULT_STAGES 3

`endif

/* logic/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    // decoded operations seen by the backend
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_MUL  = 3'd3,
        OP_LI   = 3'd4,
        OP_HALT = 3'd5
    } op_e;

    // commit status
    typedef enum logic [1:0] {
        NO_ERROR = 2'd0,
        HALTED   = 2'd1
    } exc_e;

endpackage

`default_nettype wire

/* logic/rat.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ooo_consts.svh"

module rat (
    input  wire logic              clock,
    input  wire logic              rst,
    input  wire logic              rename_en,
    input  wire logic [`ARN_W-1:0] dest_arn,
    input  wire logic [`ARN_W-1:0] src1_arn,
    input  wire logic [`ARN_W-1:0] src2_arn,
    input  wire logic              free_en,
    input  wire logic [`PRN_W-1:0] free_prn,
    output logic [`PRN_W-1:0]      src1_prn,
    output logic [`PRN_W-1:0]      src2_prn,
    output logic [`PRN_W-1:0]      dest_prn,
    output logic [`PRN_W-1:0]      old_prn,
    output logic                   free_empty
);
    localparam int CNT_W = `PRN_W + 1;

    logic [`PRN_W-1:0] map    [`NUM_ARN];
    logic [`PRN_W-1:0] free_q [`NUM_PRN];
    logic [`PRN_W-1:0] fl_head;
    logic [`PRN_W-1:0] fl_tail;
    logic [CNT_W-1:0]  fl_count;
    logic              pop;
    logic              push;

    assign src1_prn = map[src1_arn];
    assign src2_prn = map[src2_arn];
    assign old_prn  = map[dest_arn];
    // r0 stays on p0 and never takes a free register
    assign dest_prn   = (dest_arn == `ZERO_REG) ? '0 : free_q[fl_head];
    assign pop        = rename_en && (dest_arn != `ZERO_REG);
    assign push       = free_en && (free_prn != '0);
    assign free_empty = (fl_count == '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `NUM_ARN; i++) begin
                map[i] <= `PRN_W'(i);
            end
            // p8..p15 start out free
            for (int i = 0; i < `NUM_PRN; i++) begin
                free_q[i] <= `PRN_W'(i + `NUM_ARN);
            end
            fl_head  <= '0;
            fl_tail  <= `PRN_W'(`NUM_ARN);
            fl_count <= CNT_W'(`NUM_ARN);
        end else begin
            if (pop) begin
                map[dest_arn] <= free_q[fl_head];
                fl_head       <= fl_head + 1'b1;
            end
            if (push) begin
                free_q[fl_tail] <= free_prn;
                fl_tail         <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

/* logic/prf.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ooo_consts.svh"

module prf (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire logic [`PRN_W-1:0]  rd_prn1,
    input  wire logic [`PRN_W-1:0]  rd_prn2,
    output logic [`DATA_W-1:0]      rd_val1,
    output logic [`DATA_W-1:0]      rd_val2,
    output logic                    rd_ok1,
    output logic                    rd_ok2,
    input  wire logic               inval_en,
    input  wire logic [`PRN_W-1:0]  inval_prn,
    input  wire logic               li_en,
    input  wire logic [`PRN_W-1:0]  li_prn,
    input  wire logic [`DATA_W-1:0] li_value,
    input  wire logic               cdb_valid,
    input  wire logic [`PRN_W-1:0]  cdb_prn,
    input  wire logic [`DATA_W-1:0] cdb_value,
    input  wire logic [`PRN_W-1:0]  ct_prn,
    output logic [`DATA_W-1:0]      ct_value
);
    logic [`DATA_W-1:0] val [`NUM_PRN];
    logic               ok  [`NUM_PRN];

    // {valid, value}, with the bus forwarded in the cycle it writes
    function automatic logic [`DATA_W:0] lookup(input logic [`PRN_W-1:0] p);
        if (cdb_valid && (cdb_prn == p) && (p != '0)) begin
            return {1'b1, cdb_value};
        end
        return {ok[p], val[p]};
    endfunction

    always_comb begin
        {rd_ok1, rd_val1} = lookup(rd_prn1);
        {rd_ok2, rd_val2} = lookup(rd_prn2);
    end

    assign ct_value = val[ct_prn];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PRN; i++) begin
                val[i] <= '0;
                ok[i]  <= (i < `NUM_ARN);
            end
        end else begin
            // p0 is hardwired zero
            if (inval_en && (inval_prn != '0)) begin
                ok[inval_prn] <= 1'b0;
            end
            // li lands on the register renamed in the same cycle
            if (li_en && (li_prn != '0)) begin
                val[li_prn] <= li_value;
                ok[li_prn]  <= 1'b1;
            end
            if (cdb_valid && (cdb_prn != '0)) begin
                val[cdb_prn] <= cdb_value;
                ok[cdb_prn]  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/rs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ooo_consts.svh"

module rs (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire logic               ins_en,
    input  wire ooo_pkg::op_e       ins_op,
    input  wire logic [`DATA_W-1:0] ins_op1,
    input  wire logic               ins_op1_ok,
    input  wire logic [`DATA_W-1:0] ins_op2,
    input  wire logic               ins_op2_ok,
    input  wire logic [`PRN_W-1:0]  ins_dest,
    input  wire logic [`ROBN_W-1:0] ins_robn,
    input  wire logic               cdb_valid,
    input  wire logic [`PRN_W-1:0]  cdb_prn,
    input  wire logic [`DATA_W-1:0] cdb_value,
    input  wire logic               alu_avail,
    input  wire logic               mult_avail,
    output logic                    issue_valid,
    output ooo_pkg::op_e            issue_op,
    output logic [`DATA_W-1:0]      issue_a,
    output logic [`DATA_W-1:0]      issue_b,
    output logic [`PRN_W-1:0]       issue_dest,
    output logic [`ROBN_W-1:0]      issue_robn,
    output logic                    almost_full
);
    import ooo_pkg::*;

    localparam int SEL_W = $clog2(`RS_SZ);

    logic               vld  [`RS_SZ];
    op_e                op   [`RS_SZ];
    logic [`DATA_W-1:0] a    [`RS_SZ];
    logic               a_ok [`RS_SZ];
    logic [`DATA_W-1:0] b    [`RS_SZ];
    logic               b_ok [`RS_SZ];
    logic [`PRN_W-1:0]  dest [`RS_SZ];
    logic [`ROBN_W-1:0] robn [`RS_SZ];
    logic [SEL_W-1:0]   sel;
    logic [SEL_W-1:0]   ins_slot;
    logic [SEL_W:0]     used;

    // operand still holds a tag that is on the bus right now
    function automatic logic hit(input logic [`DATA_W-1:0] opnd, input logic rdy);
        return !rdy && cdb_valid && (opnd[`PRN_W-1:0] == cdb_prn);
    endfunction

    // scan downward so the lowest index wins
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        ins_slot    = '0;
        used        = '0;
        for (int i = `RS_SZ - 1; i >= 0; i--) begin
            if (vld[i] && a_ok[i] && b_ok[i] &&
                ((op[i] == OP_MUL) ? mult_avail : alu_avail)) begin
                issue_valid = 1'b1;
                sel         = SEL_W'(i);
            end
            if (!vld[i]) begin
                ins_slot = SEL_W'(i);
            end
            used = used + (SEL_W + 1)'(vld[i]);
        end
    end

    assign issue_op    = op[sel];
    assign issue_a     = a[sel];
    assign issue_b     = b[sel];
    assign issue_dest  = dest[sel];
    assign issue_robn  = robn[sel];
    assign almost_full = (used >= (SEL_W + 1)'(`RS_SZ - 1));

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `RS_SZ; i++) begin
                vld[i] <= 1'b0;
            end
        end else begin
            // wakeup
            for (int i = 0; i < `RS_SZ; i++) begin
                if (hit(a[i], a_ok[i])) begin
                    a[i]    <= cdb_value;
                    a_ok[i] <= 1'b1;
                end
                if (hit(b[i], b_ok[i])) begin
                    b[i]    <= cdb_value;
                    b_ok[i] <= 1'b1;
                end
            end
            if (issue_valid) begin
                vld[sel] <= 1'b0;
            end
            if (ins_en) begin
                vld[ins_slot]  <= 1'b1;
                op[ins_slot]   <= ins_op;
                a[ins_slot]    <= hit(ins_op1, ins_op1_ok) ? cdb_value : ins_op1;
                a_ok[ins_slot] <= ins_op1_ok || hit(ins_op1, ins_op1_ok);
                b[ins_slot]    <= hit(ins_op2, ins_op2_ok) ? cdb_value : ins_op2;
                b_ok[ins_slot] <= ins_op2_ok || hit(ins_op2, ins_op2_ok);
                dest[ins_slot] <= ins_dest;
                robn[ins_slot] <= ins_robn;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/fu_cdb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ooo_consts.svh"

module fu_cdb (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire logic               issue_valid,
    input  wire ooo_pkg::op_e       issue_op,
    input  wire logic [`DATA_W-1:0] issue_a,
    input  wire logic [`DATA_W-1:0] issue_b,
    input  wire logic [`PRN_W-1:0]  issue_dest,
    input  wire logic [`ROBN_W-1:0] issue_robn,
    output logic                    alu_avail,
    output logic                    mult_avail,
    output logic                    cdb_valid,
    output logic [`PRN_W-1:0]       cdb_prn,
    output logic [`DATA_W-1:0]      cdb_value,
    output logic [`ROBN_W-1:0]      cdb_robn
);
    import ooo_pkg::*;

    localparam int LAST = `MULT_STAGES - 1;

    logic               alu_vld;
    logic [`PRN_W-1:0]  alu_prn;
    logic [`ROBN_W-1:0] alu_robn;
    logic [`DATA_W-1:0] alu_res;
    logic [`DATA_W-1:0] alu_out;
    logic               is_mul;

    logic               m_vld  [`MULT_STAGES];
    logic [`PRN_W-1:0]  m_prn  [`MULT_STAGES];
    logic [`ROBN_W-1:0] m_robn [`MULT_STAGES];
    logic [`DATA_W-1:0] m_res  [`MULT_STAGES];

    assign is_mul = issue_valid && (issue_op == OP_MUL);

    always_comb begin
        case (issue_op)
            OP_SUB:  alu_out = issue_a - issue_b;
            OP_AND:  alu_out = issue_a & issue_b;
            default: alu_out = issue_a + issue_b;
        endcase
    end

    // an alu result issued now would collide with the multiply leaving next cycle
    assign alu_avail  = !m_vld[LAST - 1];
    // fully pipelined, one multiply accepted every cycle
    assign mult_avail = 1'b1;

    always_ff @(posedge clock) begin
        alu_prn   <= issue_dest;
        alu_robn  <= issue_robn;
        alu_res   <= alu_out;
        m_prn[0]  <= issue_dest;
        m_robn[0] <= issue_robn;
        // low half of the product only
        m_res[0]  <= issue_a * issue_b;
        for (int s = 1; s < `MULT_STAGES; s++) begin
            m_prn[s]  <= m_prn[s-1];
            m_robn[s] <= m_robn[s-1];
            m_res[s]  <= m_res[s-1];
        end
        if (rst) begin
            alu_vld <= 1'b0;
            for (int s = 0; s < `MULT_STAGES; s++) begin
                m_vld[s] <= 1'b0;
            end
        end else begin
            alu_vld  <= issue_valid && !is_mul;
            m_vld[0] <= is_mul;
            for (int s = 1; s < `MULT_STAGES; s++) begin
                m_vld[s] <= m_vld[s-1];
            end
        end
    end

    // single bus, multiplier first
    assign cdb_valid = m_vld[LAST] || alu_vld;
    assign cdb_prn   = m_vld[LAST] ? m_prn[LAST] : alu_prn;
    assign cdb_value = m_vld[LAST] ? m_res[LAST] : alu_res;
    assign cdb_robn  = m_vld[LAST] ? m_robn[LAST] : alu_robn;

endmodule

`default_nettype wire

/* logic/rob.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ooo_consts.svh"

module rob (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire logic               alloc_en,
    input  wire ooo_pkg::op_e       alloc_op,
    input  wire logic [`ARN_W-1:0]  alloc_arn,
    input  wire logic [`PRN_W-1:0]  alloc_prn,
    input  wire logic [`PRN_W-1:0]  alloc_old_prn,
    input  wire logic               alloc_done,
    output logic [`ROBN_W-1:0]      tail,
    input  wire logic               cdb_valid,
    input  wire logic [`ROBN_W-1:0] cdb_robn,
    output logic                    ct_valid,
    output logic [`ARN_W-1:0]       ct_arn,
    output logic [`PRN_W-1:0]       ct_prn,
    output logic [`PRN_W-1:0]       ct_old_prn,
    output ooo_pkg::exc_e           ct_exc,
    output logic                    almost_full
);
    import ooo_pkg::*;

    localparam int CNT_W = `ROBN_W + 1;

    logic [`ARN_W-1:0]  arn     [`ROB_SZ];
    logic [`PRN_W-1:0]  prn     [`ROB_SZ];
    logic [`PRN_W-1:0]  old_prn [`ROB_SZ];
    logic               halt    [`ROB_SZ];
    logic               done    [`ROB_SZ];
    logic [`ROBN_W-1:0] head;
    logic [CNT_W-1:0]   count;
    logic               retire;

    // head leaves once its result is in
    assign retire      = (count != '0) && done[head];
    assign almost_full = (count >= CNT_W'(`ROB_SZ - 1));

    always_ff @(posedge clock) begin
        if (alloc_en) begin
            arn[tail]     <= alloc_arn;
            prn[tail]     <= alloc_prn;
            old_prn[tail] <= alloc_old_prn;
            halt[tail]    <= (alloc_op == OP_HALT);
            done[tail]    <= alloc_done;
        end
        if (cdb_valid) begin
            done[cdb_robn] <= 1'b1;
        end
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            ct_valid   <= 1'b0;
            ct_arn     <= '0;
            ct_prn     <= '0;
            ct_old_prn <= '0;
            ct_exc     <= NO_ERROR;
        end else begin
            ct_valid <= retire;
            if (retire) begin
                ct_arn     <= arn[head];
                ct_prn     <= prn[head];
                ct_old_prn <= old_prn[head];
                ct_exc     <= halt[head] ? HALTED : NO_ERROR;
                head       <= head + 1'b1;
            end
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
            count <= count + CNT_W'(alloc_en) - CNT_W'(retire);
        end
    end

endmodule

`default_nettype wire

/* logic/ooo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ooo_consts.svh"

module ooo (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire logic               in_valid,
    input  wire ooo_pkg::op_e       in_op,
    input  wire logic [`ARN_W-1:0]  in_dest,
    input  wire logic [`ARN_W-1:0]  in_src1,
    input  wire logic [`ARN_W-1:0]  in_src2,
    input  wire logic [`DATA_W-1:0] in_imm,
    output logic                    structural_hazard,
    output logic                    ct_valid,
    output logic                    ct_wr_en,
    output logic [`ARN_W-1:0]       ct_wr_idx,
    output logic [`DATA_W-1:0]      ct_wr_data,
    output ooo_pkg::exc_e           ct_exception
);
    import ooo_pkg::*;

    logic               accept;
    logic               is_li;
    logic               is_halt;
    logic [`ARN_W-1:0]  ren_dest;
    logic [`PRN_W-1:0]  src1_prn, src2_prn, dest_prn, old_prn;
    logic               free_empty;
    logic [`DATA_W-1:0] rd_val1, rd_val2;
    logic               rd_ok1, rd_ok2;
    logic [`DATA_W-1:0] op1, op2;
    logic               rs_almost_full;
    logic               rob_almost_full;
    logic [`ROBN_W-1:0] rob_tail;
    logic               issue_valid;
    op_e                issue_op;
    logic [`DATA_W-1:0] issue_a, issue_b;
    logic [`PRN_W-1:0]  issue_dest;
    logic [`ROBN_W-1:0] issue_robn;
    logic               alu_avail, mult_avail;
    logic               cdb_valid;
    logic [`PRN_W-1:0]  cdb_prn;
    logic [`DATA_W-1:0] cdb_value;
    logic [`ROBN_W-1:0] cdb_robn;
    logic [`PRN_W-1:0]  ct_prn, ct_old_prn;

    // issue
    assign accept  = in_valid && !structural_hazard;
    assign is_li   = (in_op == OP_LI);
    assign is_halt = (in_op == OP_HALT);
    // halt gets no destination register
    assign ren_dest = is_halt ? `ZERO_REG : in_dest;
    // a source not yet produced travels as its tag
    assign op1 = rd_ok1 ? rd_val1 : `DATA_W'(src1_prn);
    assign op2 = rd_ok2 ? rd_val2 : `DATA_W'(src2_prn);

    assign structural_hazard = rs_almost_full || rob_almost_full || free_empty;

    // commit
    assign ct_wr_en = ct_valid && (ct_exception != HALTED) && (ct_wr_idx != `ZERO_REG);

    rat u_rat (
        .clock(clock), .rst(rst),
        .rename_en(accept), .dest_arn(ren_dest), .src1_arn(in_src1), .src2_arn(in_src2),
        .free_en(ct_valid), .free_prn(ct_old_prn),
        .src1_prn(src1_prn), .src2_prn(src2_prn), .dest_prn(dest_prn), .old_prn(old_prn),
        .free_empty(free_empty)
    );

    prf u_prf (
        .clock(clock), .rst(rst),
        .rd_prn1(src1_prn), .rd_prn2(src2_prn),
        .rd_val1(rd_val1), .rd_val2(rd_val2), .rd_ok1(rd_ok1), .rd_ok2(rd_ok2),
        .inval_en(accept), .inval_prn(dest_prn),
        .li_en(accept && is_li), .li_prn(dest_prn), .li_value(in_imm),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn), .cdb_value(cdb_value),
        .ct_prn(ct_prn), .ct_value(ct_wr_data)
    );

    rs u_rs (
        .clock(clock), .rst(rst),
        .ins_en(accept && !is_li && !is_halt), .ins_op(in_op),
        .ins_op1(op1), .ins_op1_ok(rd_ok1), .ins_op2(op2), .ins_op2_ok(rd_ok2),
        .ins_dest(dest_prn), .ins_robn(rob_tail),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn), .cdb_value(cdb_value),
        .alu_avail(alu_avail), .mult_avail(mult_avail),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a),
        .issue_b(issue_b), .issue_dest(issue_dest), .issue_robn(issue_robn),
        .almost_full(rs_almost_full)
    );

    fu_cdb u_fu_cdb (
        .clock(clock), .rst(rst),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a),
        .issue_b(issue_b), .issue_dest(issue_dest), .issue_robn(issue_robn),
        .alu_avail(alu_avail), .mult_avail(mult_avail),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn), .cdb_value(cdb_value), .cdb_robn(cdb_robn)
    );

    // li and halt enter already executed
    rob u_rob (
        .clock(clock), .rst(rst),
        .alloc_en(accept), .alloc_op(in_op), .alloc_arn(ren_dest), .alloc_prn(dest_prn),
        .alloc_old_prn(old_prn), .alloc_done(is_li || is_halt), .tail(rob_tail),
        .cdb_valid(cdb_valid), .cdb_robn(cdb_robn),
        .ct_valid(ct_valid), .ct_arn(ct_wr_idx), .ct_prn(ct_prn), .ct_old_prn(ct_old_prn),
        .ct_exc(ct_exception), .almost_full(rob_almost_full)
    );

endmodule

`default_nettype wire

/* tb/ooo_assertions.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ooo_consts.svh"

module ooo_assertions (
    input wire logic               clock,
    input wire logic               rst,
    input wire logic               in_valid,
    input wire logic               structural_hazard,
    input wire logic               ct_valid,
    input wire logic               ct_wr_en,
    input wire logic [`ARN_W-1:0]  ct_wr_idx,
    input wire logic [`DATA_W-1:0] ct_wr_data,
    input wire ooo_pkg::exc_e      ct_exception
);
    // source holds off while the core is full
    a_no_valid_on_hazard: assert property (@(posedge clock) disable iff (rst)
        !(in_valid && structural_hazard))
        else $error("in_valid was high while structural_hazard was high");

    // r0 never takes a write
    a_zero_reg_no_write: assert property (@(posedge clock) disable iff (rst)
        (ct_wr_idx == `ZERO_REG) |-> !ct_wr_en)
        else $error("ct_wr_en was high for architectural register 0");

    a_known: assert property (@(posedge clock) disable iff (rst)
        !$isunknown({in_valid, structural_hazard, ct_valid, ct_wr_en, ct_wr_idx,
                     ct_wr_data, ct_exception}))
        else $error("an interface signal of ooo was unknown after reset");

endmodule

`default_nettype wire

/* tb/ooo_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ooo_consts.svh"

module ooo_tb;
    import ooo_pkg::*;

    localparam int MAX_N      = 48;
    localparam int NUM_TESTS  = 7;
    localparam int BURST_TEST = 3;

    logic               clock;
    logic               rst;
    logic               in_valid;
    op_e                in_op;
    logic [`ARN_W-1:0]  in_dest;
    logic [`ARN_W-1:0]  in_src1;
    logic [`ARN_W-1:0]  in_src2;
    logic [`DATA_W-1:0] in_imm;
    logic               structural_hazard;
    logic               ct_valid;
    logic               ct_wr_en;
    logic [`ARN_W-1:0]  ct_wr_idx;
    logic [`DATA_W-1:0] ct_wr_data;
    exc_e               ct_exception;

    // program table, stimulus columns then expected commit columns
    int                 t_test  [MAX_N];
    op_e                t_op    [MAX_N];
    logic [`ARN_W-1:0]  t_dest  [MAX_N];
    logic [`ARN_W-1:0]  t_src1  [MAX_N];
    logic [`ARN_W-1:0]  t_src2  [MAX_N];
    logic [`DATA_W-1:0] t_imm   [MAX_N];
    logic               e_wr_en [MAX_N];
    logic [`ARN_W-1:0]  e_idx   [MAX_N];
    logic [`DATA_W-1:0] e_data  [MAX_N];
    exc_e               e_exc   [MAX_N];

    string test_name [NUM_TESTS] = '{"li", "alu chain", "mul then alu", "mul burst",
                                     "zero reg", "random", "halt"};
    int                 test_last   [NUM_TESTS];
    int                 test_err    [NUM_TESTS];
    int                 hazard_hits [NUM_TESTS];
    int                 n_instr;
    int                 ci;
    int                 errors;
    int                 cycles;
    int                 limit;
    logic [`DATA_W-1:0] rnd;

    ooo u_ooo (
        .clock(clock), .rst(rst),
        .in_valid(in_valid), .in_op(in_op), .in_dest(in_dest), .in_src1(in_src1),
        .in_src2(in_src2), .in_imm(in_imm), .structural_hazard(structural_hazard),
        .ct_valid(ct_valid), .ct_wr_en(ct_wr_en), .ct_wr_idx(ct_wr_idx),
        .ct_wr_data(ct_wr_data), .ct_exception(ct_exception)
    );

    bind ooo ooo_assertions u_ooo_assertions (
        .clock(clock), .rst(rst), .in_valid(in_valid),
        .structural_hazard(structural_hazard), .ct_valid(ct_valid), .ct_wr_en(ct_wr_en),
        .ct_wr_idx(ct_wr_idx), .ct_wr_data(ct_wr_data), .ct_exception(ct_exception)
    );

    always #4 clock = ~clock;

    function automatic logic [`DATA_W-1:0] xorshift(input logic [`DATA_W-1:0] x);
        logic [`DATA_W-1:0] y;
        y = x ^ (x << 7);
        y = y ^ (y >> 9);
        return y ^ (y << 8);
    endfunction

    task automatic add_instr(input int test, input op_e op, input int d, input int s1,
                             input int s2, input int imm);
        t_test[n_instr] = test;
        t_op[n_instr]   = op;
        t_dest[n_instr] = `ARN_W'(d);
        t_src1[n_instr] = `ARN_W'(s1);
        t_src2[n_instr] = `ARN_W'(s2);
        t_imm[n_instr]  = `DATA_W'(imm);
        test_last[test] = n_instr;
        n_instr++;
    endtask

    task automatic build_program();
        op_e rop;
        rnd = `DATA_W'(37);
        for (int r = 1; r < `NUM_ARN; r++) begin
            add_instr(0, OP_LI, r, 0, 0, r * 291 + 64);
        end
        // dependent chain through r3..r7
        add_instr(1, OP_ADD, 3, 1, 2, 0);
        add_instr(1, OP_SUB, 4, 3, 1, 0);
        add_instr(1, OP_AND, 5, 4, 2, 0);
        add_instr(1, OP_ADD, 3, 3, 3, 0);
        add_instr(1, OP_SUB, 6, 5, 3, 0);
        add_instr(1, OP_ADD, 7, 6, 6, 0);
        // alu ops overtake the multiply, last one waits on it
        add_instr(2, OP_MUL, 1, 2, 3, 0);
        add_instr(2, OP_ADD, 4, 5, 6, 0);
        add_instr(2, OP_SUB, 5, 7, 2, 0);
        add_instr(2, OP_AND, 6, 2, 3, 0);
        add_instr(2, OP_ADD, 7, 1, 4, 0);
        add_instr(3, OP_LI, 2, 0, 0, 3);
        add_instr(3, OP_LI, 3, 0, 0, 5);
        for (int k = 0; k < 7; k++) begin
            add_instr(3, OP_MUL, 2, 2, 3, 0);
        end
        add_instr(4, OP_LI, 0, 0, 0, 'h1234);
        add_instr(4, OP_ADD, 0, 1, 2, 0);
        add_instr(4, OP_ADD, 1, 0, 0, 0);
        add_instr(4, OP_MUL, 2, 0, 3, 0);
        add_instr(4, OP_LI, 3, 0, 0, 'h55);
        add_instr(4, OP_AND, 4, 0, 3, 0);
        for (int k = 0; k < 8; k++) begin
            rnd = xorshift(rnd);
            case (rnd[4:3])
                2'd0:    rop = OP_ADD;
                2'd1:    rop = OP_SUB;
                2'd2:    rop = OP_AND;
                default: rop = OP_MUL;
            endcase
            if (k % 2 == 0) begin
                rop = OP_LI;
            end
            add_instr(5, rop, int'(rnd[2:0]) % 7 + 1, int'(rnd[7:5]), int'(rnd[10:8]),
                      int'(rnd));
        end
        add_instr(6, OP_HALT, 0, 0, 0, 0);
    endtask

    // architectural model walked in program order
    task automatic fill_expected();
        logic [`DATA_W-1:0] g [`NUM_ARN];
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] v;
        for (int r = 0; r < `NUM_ARN; r++) begin
            g[r] = '0;
        end
        for (int i = 0; i < n_instr; i++) begin
            a = g[t_src1[i]];
            b = g[t_src2[i]];
            case (t_op[i])
                OP_LI:   v = t_imm[i];
                OP_SUB:  v = a - b;
                OP_AND:  v = a & b;
                OP_MUL:  v = a * b;
                default: v = a + b;
            endcase
            e_exc[i]   = (t_op[i] == OP_HALT) ? HALTED : NO_ERROR;
            e_idx[i]   = (t_op[i] == OP_HALT) ? '0 : t_dest[i];
            e_wr_en[i] = (t_op[i] != OP_HALT) && (t_dest[i] != '0);
            e_data[i]  = v;
            if (e_wr_en[i]) begin
                g[t_dest[i]] = v;
            end
        end
    endtask

    // offer an instruction only once the hazard was seen low, for one cycle
    task automatic send(input int i);
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clock);
            busy = structural_hazard;
            if (busy) begin
                hazard_hits[t_test[i]]++;
            end
            @(posedge clock);
        end
        in_valid <= 1'b1;
        in_op    <= t_op[i];
        in_dest  <= t_dest[i];
        in_src1  <= t_src1[i];
        in_src2  <= t_src2[i];
        in_imm   <= t_imm[i];
        @(posedge clock);
        in_valid <= 1'b0;
    endtask

    task automatic mismatch(input int k, input string sig, input logic [`DATA_W-1:0] got,
                            input logic [`DATA_W-1:0] exp);
        errors++;
        test_err[t_test[k]]++;
        $display("FAIL %s at instruction %0d: got %h expected %h", sig, k, got, exp);
    endtask

    task automatic check_commit(input int k);
        int t;
        t = t_test[k];
        assert (ct_exception == e_exc[k])
            else mismatch(k, "ct_exception", 16'(ct_exception), 16'(e_exc[k]));
        assert (ct_wr_idx == e_idx[k])
            else mismatch(k, "ct_wr_idx", 16'(ct_wr_idx), 16'(e_idx[k]));
        assert (ct_wr_en == e_wr_en[k])
            else mismatch(k, "ct_wr_en", 16'(ct_wr_en), 16'(e_wr_en[k]));
        if (e_wr_en[k]) begin
            assert (ct_wr_data == e_data[k])
                else mismatch(k, "ct_wr_data", ct_wr_data, e_data[k]);
        end
        if (k == test_last[t]) begin
            if (t == BURST_TEST) begin
                assert (hazard_hits[t] > 0) else begin
                    errors++;
                    test_err[t]++;
                    $display("structural_hazard never went high during the multiply burst");
                end
            end
            $display("test %0d %s: %0d errors", t, test_name[t], test_err[t]);
        end
    endtask

    // commits are stable between edges
    always @(negedge clock) begin
        if (!rst && ct_valid) begin
            assert (ci < n_instr) else begin
                errors++;
                $display("a commit arrived after the whole program had already retired");
            end
            if (ci < n_instr) begin
                check_commit(ci);
                ci++;
            end
        end
    end

    always @(posedge clock) begin
        if (!rst) begin
            cycles <= cycles + 1;
            if (cycles > limit) begin
                $display("timeout: only %0d of %0d instructions committed in %0d cycles",
                         ci, n_instr, limit);
                $display("Errors found");
                $finish;
            end
        end
    end

    initial begin
        clock    = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = OP_ADD;
        in_dest  = '0;
        in_src1  = '0;
        in_src2  = '0;
        in_imm   = '0;
        n_instr  = 0;
        ci       = 0;
        errors   = 0;
        cycles   = 0;
        build_program();
        fill_expected();
        limit = 12 * n_instr + 100;
        repeat (8) @(posedge clock);
        rst <= 1'b0;
        for (int i = 0; i < n_instr; i++) begin
            send(i);
        end
        while (ci < n_instr) begin
            @(posedge clock);
        end
        // idle a little so a stray commit still shows up
        repeat (10) @(posedge clock);
        $display("%0d instructions, %0d commits checked, %0d errors", n_instr, ci, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/ooo_pkg.sv
logic/rat.sv
logic/prf.sv
logic/rs.sv
logic/fu_cdb.sv
logic/rob.sv
logic/ooo.sv
tb/ooo_assertions.sv
tb/ooo_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ooo_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
